//--- singleBusCpu.f
+incdir+hw
+incdir+bench
hw/cpuPkg.sv
hw/regFile.sv
hw/selectEncode.sv
hw/alu.sv
hw/memoryUnit.sv
hw/datapath.sv
bench/datapathTb.sv

//--- Bender.yml
package:
  name: singleBusCpu

sources:
  - include_dirs:
      - hw
    files:
      - hw/cpuPkg.sv
      - hw/regFile.sv
      - hw/selectEncode.sv
      - hw/alu.sv
      - hw/memoryUnit.sv
      - hw/datapath.sv
  - target: test
    include_dirs:
      - hw
      - bench
    files:
      - bench/datapathTb.sv

//--- bench/datapathRef.svh
`ifndef DATAPATH_REF_SVH
`define DATAPATH_REF_SVH

`include "cpu_defines.svh"

// Memory contents expected after each issued write
wordT memModel [`MEM_DEPTH];

// Expected 64-bit Z value for one ALU operation
function automatic dwordT aluRef(aluOpT op, wordT a, wordT b);
        longint sa;
        longint sb;
        longint q;
        int sh;
        wordT lo;
        wordT hi;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        sh = int'(b % `WORD_WIDTH);  // Low five bits of B
        lo = '0;
        hi = '0;
        case (op)
                LD, ADD: lo = a + b;
                SUB:     lo = a + ~b + 1'b1;
                MUL:     {hi, lo} = sa * sb;
                DIV: begin
                        if (sb != 0) begin
                                q = sa / sb;
                                lo = wordT'(q);
                                hi = wordT'(sa - q * sb);  // Remainder keeps the sign of A
                        end
                end
                SHR:     lo = a >> sh;
                SHL:     lo = a << sh;
                SHRA: begin
                        lo = a >> sh;
                        if (a[`WORD_WIDTH-1])
                                lo = lo | ~({`WORD_WIDTH{1'b1}} >> sh);  // Fill with sign
                end
                ROR:     for (int i = 0; i < `WORD_WIDTH; i++) lo[i] = a[(i + sh) % `WORD_WIDTH];
                ROL:     for (int i = 0; i < `WORD_WIDTH; i++) lo[(i + sh) % `WORD_WIDTH] = a[i];
                AND:     lo = a & b;
                OR:      lo = a | b;
                NEG:     lo = ~b + 1'b1;
                XOR:     lo = a ^ b;
                NOR:     lo = ~(a | b);
                NOT:     lo = ~b;
                default: lo = '0;
        endcase
        return {hi, lo};
endfunction

task automatic compareWord(string testName, wordT expected, wordT actual);
        if (actual !== expected) begin
                $display("[ERROR] %s: expected %h, actual %h", testName, expected, actual);
                $display("=== FAIL ===");
                $fatal(1, "Output port value mismatch");
        end
endtask

`endif

//--- bench/datapathTb.sv
`timescale 1ns/1ps

module datapathTb;
        import cpuPkg::*;

        localparam int clkPeriod = 8;
        localparam int aluTests = 14;
        // Reset, reset check, load, ALU, MUL/DIV, PC increment, drain
        localparam int schedSteps = 5 + 1 + 23 + aluTests * 5 + 3 * 8 + 5 + 2;

        logic clk;
        logic rst;
        logic MARin, MDRin, HIin, LOin, Yin, Zin, PCin, IRin, Rin, InPortIn, OutPortIn;
        logic Rout, BAout, Cout, MDRout, PCout, HIout, LOout, ZHighOut, ZLowOut, InPortOut;
        logic Gra, Grb, Grc, incPC, read, write;
        aluOpT opcode;
        wordT InPortData;
        wordT outPortData;

        string nameQ[$];  // Pending outport checks
        wordT expQ[$];
        int checksIssued;
        int checksDone;

        `include "datapathRef.svh"

        datapath UUT (.*);

        initial begin
                clk = 1'b0;
                forever #(clkPeriod / 2) clk = ~clk;
        end

        task automatic clearStrobes();
                {MARin, MDRin, HIin, LOin, Yin, Zin, PCin, IRin, Rin, InPortIn, OutPortIn} = '0;
                {Rout, BAout, Cout, MDRout, PCout, HIout, LOout, ZHighOut, ZLowOut, InPortOut} = '0;
                {Gra, Grb, Grc, incPC, read, write} = '0;
                opcode = LD;
        endtask

        // Hold the current control word for one clock
        task automatic endStep();
                @(posedge clk);
                #1;
                clearStrobes();
        endtask

        task automatic expectOut(string name, wordT expected);
                nameQ.push_back(name);
                expQ.push_back(expected);
                checksIssued++;
        endtask

        // Caller selects the bus source and this step captures it in the outport
        task automatic outStep(string name, wordT expected);
                OutPortIn = 1'b1;
                endStep();
                expectOut(name, expected);
        endtask

        task automatic loadInport(wordT value);
                InPortData = value;
                InPortIn = 1'b1;
                endStep();
        endtask

        task automatic memWrite(int addr, wordT data);
                loadInport(data);
                InPortOut = 1'b1;
                MDRin = 1'b1;  // MDR takes the bus since read stays low
                endStep();
                loadInport(wordT'(addr));
                InPortOut = 1'b1;
                MARin = 1'b1;
                endStep();
                write = 1'b1;
                endStep();
                memModel[addr] = data;
        endtask

        // Y gets A and then B goes on the bus while Z captures
        task automatic aluCompute(aluOpT op, wordT a, wordT b);
                loadInport(a);
                InPortOut = 1'b1;
                Yin = 1'b1;
                endStep();
                loadInport(b);
                InPortOut = 1'b1;
                Zin = 1'b1;
                opcode = op;
                endStep();
        endtask

        task automatic checkAluOp(aluOpT op, wordT a, wordT b);
                dwordT expected;
                expected = aluRef(op, a, b);
                aluCompute(op, a, b);
                ZLowOut = 1'b1;
                outStep($sformatf("alu %s", op.name()), expected[`WORD_WIDTH-1:0]);
        endtask

        task automatic checkMulDiv(aluOpT op, wordT a, wordT b);
                dwordT expected;
                expected = aluRef(op, a, b);
                aluCompute(op, a, b);
                ZHighOut = 1'b1;
                HIin = 1'b1;
                endStep();
                ZLowOut = 1'b1;
                LOin = 1'b1;
                endStep();
                HIout = 1'b1;
                outStep($sformatf("%s high", op.name()), expected[2*`WORD_WIDTH-1:`WORD_WIDTH]);
                LOout = 1'b1;
                outStep($sformatf("%s low", op.name()), expected[`WORD_WIDTH-1:0]);
        endtask

        // ld R1, C(R0) fetched from memory and executed in T0 to T7
        task automatic runLoadInstr();
                int dataAddr;
                int instrAddr;
                wordT instr;
                dataAddr = $urandom_range(0, 255);
                instrAddr = $urandom_range(256, `MEM_DEPTH - 1);
                instr = '0;
                instr[`OPCODE_MSB -: 5] = LD;
                instr[`RA_MSB -: 4] = 4'd1;
                instr[`RB_MSB -: 4] = 4'd0;
                instr[`CONST_WIDTH-1:0] = dataAddr;
                memWrite(dataAddr, $urandom);
                memWrite(instrAddr, instr);
                loadInport($urandom | 32'h1);  // Nonzero R0 that BAout has to mask
                InPortOut = 1'b1;
                Rin = 1'b1;
                endStep();
                loadInport(wordT'(instrAddr));
                InPortOut = 1'b1;
                PCin = 1'b1;
                endStep();
                PCout = 1'b1;  // T0
                MARin = 1'b1;
                incPC = 1'b1;
                Zin = 1'b1;
                endStep();
                ZLowOut = 1'b1;  // T1
                PCin = 1'b1;
                read = 1'b1;
                MDRin = 1'b1;
                endStep();
                MDRout = 1'b1;  // T2
                IRin = 1'b1;
                endStep();
                Grb = 1'b1;  // T3 with base R0 read as zero
                BAout = 1'b1;
                Yin = 1'b1;
                endStep();
                Cout = 1'b1;  // T4
                Zin = 1'b1;
                opcode = LD;
                endStep();
                ZLowOut = 1'b1;  // T5
                MARin = 1'b1;
                endStep();
                read = 1'b1;  // T6
                MDRin = 1'b1;
                endStep();
                MDRout = 1'b1;  // T7
                Gra = 1'b1;
                Rin = 1'b1;
                endStep();
                Gra = 1'b1;
                Rout = 1'b1;
                outStep("load R1", memModel[dataAddr]);
        endtask

        // Outport sampled mid-cycle once the edge update has settled
        initial begin : comparator
                string name;
                wordT expected;
                forever begin
                        @(negedge clk);
                        while (nameQ.size() > 0) begin
                                name = nameQ.pop_front();
                                expected = expQ.pop_front();
                                compareWord(name, expected, outPortData);
                                checksDone++;
                        end
                end
        end

        initial begin : watchdog
                #(2 * schedSteps * clkPeriod);
                $display("Watchdog expired: run did not finish within %0d ns",
                         2 * schedSteps * clkPeriod);
                $display("=== FAIL ===");
                $fatal(1, "Simulation hang");
        end

        initial begin : stimulus
                aluOpT regOps [aluTests];
                wordT pcVal;
                void'($urandom(32'h18e9));
                regOps = '{LD, ADD, SUB, SHR, SHL, SHRA, ROR, ROL, AND, OR, NEG, XOR, NOR, NOT};
                rst = 1'b1;
                InPortData = '0;
                clearStrobes();
                repeat (5) @(posedge clk);
                #1;
                rst = 1'b0;

                expectOut("reset outport", '0);
                HIout = 1'b1;
                outStep("reset HI", '0);

                runLoadInstr();

                foreach (regOps[i]) checkAluOp(regOps[i], $urandom, $urandom);

                checkMulDiv(MUL, $urandom, $urandom);
                checkMulDiv(DIV, $urandom, $urandom_range(1, 32'h7fff) | ($urandom & 32'h8000_0000));
                checkMulDiv(DIV, $urandom, '0);  // Zero divisor

                pcVal = $urandom;
                loadInport(pcVal);
                InPortOut = 1'b1;
                PCin = 1'b1;
                endStep();
                PCout = 1'b1;
                incPC = 1'b1;
                Zin = 1'b1;
                endStep();
                ZLowOut = 1'b1;
                PCin = 1'b1;
                endStep();
                PCout = 1'b1;
                outStep("pc increment", pcVal + 1);

                repeat (2) @(negedge clk);
                if (checksIssued > 0 && checksDone == checksIssued) begin
                        $display("=== PASS ===");
                end else begin
                        $display("Only %0d of %0d checks ran", checksDone, checksIssued);
                        $display("=== FAIL ===");
                end
                $finish;
        end

endmodule

//--- hw/datapath.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module datapath (
        input  logic          clk,
        input  logic          rst,
        // Register load enables
        input  logic          MARin,
        input  logic          MDRin,
        input  logic          HIin,
        input  logic          LOin,
        input  logic          Yin,
        input  logic          Zin,
        input  logic          PCin,
        input  logic          IRin,
        input  logic          Rin,
        input  logic          InPortIn,
        input  logic          OutPortIn,
        // Bus source enables
        input  logic          Rout,
        input  logic          BAout,
        input  logic          Cout,
        input  logic          MDRout,
        input  logic          PCout,
        input  logic          HIout,
        input  logic          LOout,
        input  logic          ZHighOut,
        input  logic          ZLowOut,
        input  logic          InPortOut,
        // Register select, ALU and memory strobes
        input  logic          Gra,
        input  logic          Grb,
        input  logic          Grc,
        input  logic          incPC,
        input  logic          read,
        input  logic          write,
        input  cpuPkg::aluOpT opcode,
        input  cpuPkg::wordT  InPortData,
        output cpuPkg::wordT  outPortData
);
        import cpuPkg::*;

        wordT bus;
        wordT pc;
        wordT ir;
        wordT yReg;
        wordT hiReg;
        wordT loReg;
        wordT inPort;
        wordT outPort;
        dwordT zReg;

        wordT regBus;
        wordT constant;
        wordT mdrOut;
        regIdxT regIdx;
        dwordT aluResult;

        selectEncode selEnc (
                .Gra(Gra), .Grb(Grb), .Grc(Grc),
                .ir(ir), .idx(regIdx), .constant(constant)
        );

        regFile gpRegs (
                .clk(clk), .rst(rst), .Rin(Rin), .Rout(Rout), .BAout(BAout),
                .idx(regIdx), .busIn(bus), .busOut(regBus)
        );

        alu aluUnit (
                .op(opcode), .incPC(incPC), .a(yReg), .b(bus), .result(aluResult)
        );

        memoryUnit memUnit (
                .clk(clk), .rst(rst), .MARin(MARin), .MDRin(MDRin), .read(read),
                .write(write), .busIn(bus), .mdrOut(mdrOut)
        );

        // Single bus, driven by whichever source is enabled
        always_comb begin
                bus = '0;
                if (Rout || BAout)  bus = regBus;
                else if (Cout)      bus = constant;
                else if (MDRout)    bus = mdrOut;
                else if (PCout)     bus = pc;
                else if (HIout)     bus = hiReg;
                else if (LOout)     bus = loReg;
                else if (ZHighOut)  bus = zReg[2*`WORD_WIDTH-1:`WORD_WIDTH];
                else if (ZLowOut)   bus = zReg[`WORD_WIDTH-1:0];
                else if (InPortOut) bus = inPort;
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        pc      <= '0;
                        ir      <= '0;
                        yReg    <= '0;
                        zReg    <= '0;
                        hiReg   <= '0;
                        loReg   <= '0;
                        inPort  <= '0;
                        outPort <= '0;
                end else begin
                        if (PCin)      pc      <= bus;
                        if (IRin)      ir      <= bus;
                        if (Yin)       yReg    <= bus;  // ALU A operand
                        if (Zin)       zReg    <= aluResult;
                        if (HIin)      hiReg   <= bus;
                        if (LOin)      loReg   <= bus;
                        if (InPortIn)  inPort  <= InPortData;  // Off-chip side, not the bus
                        if (OutPortIn) outPort <= bus;
                end
        end

        assign outPortData = outPort;

        // Control word must not fight over the bus
        busOneSource: assert property (@(posedge clk) disable iff (rst)
                $onehot0({Rout, BAout, Cout, MDRout, PCout, HIout, LOout,
                          ZHighOut, ZLowOut, InPortOut}))
                else $error("More than one source driving the bus");

endmodule

//--- hw/memoryUnit.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module memoryUnit (
        input  logic         clk,
        input  logic         rst,
        input  logic         MARin,
        input  logic         MDRin,
        input  logic         read,
        input  logic         write,
        input  cpuPkg::wordT busIn,
        output cpuPkg::wordT mdrOut
);
        import cpuPkg::*;

        localparam int addrWidth = $clog2(`MEM_DEPTH);

        logic [addrWidth-1:0] mar;
        wordT mdr;
        wordT memData;
        wordT mem [`MEM_DEPTH];

        // Asynchronous read so a load finishes within its step
        assign memData = mem[mar];

        always_ff @(posedge clk) begin
                if (rst) begin
                        mar <= '0;
                        mdr <= '0;
                end else begin
                        if (MARin) begin
                                mar <= busIn[addrWidth-1:0];  // Upper address bits dropped
                        end
                        if (MDRin) begin
                                mdr <= read ? memData : busIn;
                        end
                end
        end

        // Store path always takes its data from MDR
        always_ff @(posedge clk) begin
                if (write) begin
                        mem[mar] <= mdr;
                end
        end

        assign mdrOut = mdr;

        // A single step either reads or writes memory, never both
        rdWrExclusive: assert property (@(posedge clk) disable iff (rst)
                !(read && write))
                else $error("Memory read and write issued in the same step");

endmodule

//--- hw/alu.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module alu (
        input  cpuPkg::aluOpT op,
        input  logic          incPC,
        input  cpuPkg::wordT  a,
        input  cpuPkg::wordT  b,
        output cpuPkg::dwordT result
);
        import cpuPkg::*;

        localparam int shWidth = $clog2(`WORD_WIDTH);

        logic [shWidth-1:0] shAmt;
        logic signed [2*`WORD_WIDTH-1:0] product;
        logic signed [`WORD_WIDTH-1:0] quotient;
        logic signed [`WORD_WIDTH-1:0] remainder;
        wordT rotRight;
        wordT rotLeft;
        wordT lo;
        wordT hi;

        assign shAmt = b[shWidth-1:0];  // Only the low bits of B count

        // Signed multiply over the full double width
        assign product = $signed(a) * $signed(b);

        // Signed divide with a zero divisor giving zero in both halves
        always_comb begin
                if (b == '0) begin
                        quotient  = '0;
                        remainder = '0;
                end else begin
                        quotient  = $signed(a) / $signed(b);
                        remainder = $signed(a) % $signed(b);
                end
        end

        // A zero amount shifts the other half out entirely
        assign rotRight = (a >> shAmt) | (a << (`WORD_WIDTH - shAmt));
        assign rotLeft  = (a << shAmt) | (a >> (`WORD_WIDTH - shAmt));

        always_comb begin
                lo = '0;
                hi = '0;
                if (incPC) begin
                        lo = b + 1'b1;  // PC increment overrides the opcode
                end else begin
                        case (op)
                                LD, ADD: lo = a + b;
                                SUB:     lo = a - b;
                                MUL: begin
                                        lo = product[`WORD_WIDTH-1:0];
                                        hi = product[2*`WORD_WIDTH-1:`WORD_WIDTH];
                                end
                                DIV: begin
                                        lo = quotient;
                                        hi = remainder;
                                end
                                SHR:     lo = a >> shAmt;
                                SHL:     lo = a << shAmt;
                                SHRA:    lo = $signed(a) >>> shAmt;
                                ROR:     lo = rotRight;
                                ROL:     lo = rotLeft;
                                AND:     lo = a & b;
                                OR:      lo = a | b;
                                NEG:     lo = -b;
                                XOR:     lo = a ^ b;
                                NOR:     lo = ~(a | b);
                                NOT:     lo = ~b;
                                default: lo = '0;
                        endcase
                end
        end

        assign result = {hi, lo};

endmodule

//--- hw/selectEncode.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module selectEncode (
        input  logic           Gra,
        input  logic           Grb,
        input  logic           Grc,
        input  cpuPkg::wordT   ir,
        output cpuPkg::regIdxT idx,
        output cpuPkg::wordT   constant
);
        import cpuPkg::*;

        localparam int idxWidth = $bits(regIdxT);

        regIdxT raField;
        regIdxT rbField;
        regIdxT rcField;

        assign raField = ir[`RA_MSB -: idxWidth];
        assign rbField = ir[`RB_MSB -: idxWidth];
        assign rcField = ir[`RC_MSB -: idxWidth];

        always_comb begin
                if (Gra) begin
                        idx = raField;
                end else if (Grb) begin
                        idx = rbField;
                end else if (Grc) begin
                        idx = rcField;
                end else begin
                        idx = '0;
                end
        end

        // Immediate field, sign-extended to a full word
        assign constant = {{(`WORD_WIDTH - `CONST_WIDTH){ir[`CONST_WIDTH-1]}},
                           ir[`CONST_WIDTH-1:0]};

        // Control steps select one register field at a time
        selOneHot: assert final ($onehot0({Gra, Grb, Grc}))
                else $error("More than one register select line is high");

endmodule

//--- hw/regFile.sv
`timescale 1ns/1ps
`include "cpu_defines.svh"

module regFile (
        input  logic           clk,
        input  logic           rst,
        input  logic           Rin,
        input  logic           Rout,
        input  logic           BAout,
        input  cpuPkg::regIdxT idx,
        input  cpuPkg::wordT   busIn,
        output cpuPkg::wordT   busOut
);
        import cpuPkg::*;

        wordT regs [`REG_COUNT];

        // Write port, register picked by the select-and-encode block
        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int i = 0; i < `REG_COUNT; i++) begin
                                regs[i] <= '0;
                        end
                end else if (Rin) begin
                        regs[idx] <= busIn;
                end
        end

        // Base-address read turns R0 into a constant zero
        always_comb begin
                if (BAout && idx == '0) begin
                        busOut = '0;
                end else if (Rout || BAout) begin
                        busOut = regs[idx];
                end else begin
                        busOut = '0;  // Not driving the bus
                end
        end

endmodule

//--- hw/cpuPkg.sv
`include "cpu_defines.svh"

package cpuPkg;

        // Bus and register value
        typedef logic [`WORD_WIDTH-1:0] wordT;

        // Full ALU result held in Z
        typedef logic [2*`WORD_WIDTH-1:0] dwordT;

        // General register index
        typedef logic [$clog2(`REG_COUNT)-1:0] regIdxT;

        // ALU operation codes, matching the instruction opcode field
        typedef enum logic [4:0] {
                LD   = 5'd0,  // Address computation, same as ADD
                ADD  = 5'd1,
                SUB  = 5'd2,
                MUL  = 5'd3,  // Signed, full 64-bit product
                DIV  = 5'd4,  // Quotient low, remainder high
                SHR  = 5'd5,
                SHL  = 5'd6,
                SHRA = 5'd7,
                ROR  = 5'd8,
                ROL  = 5'd9,
                AND  = 5'd10,
                OR   = 5'd11,
                NEG  = 5'd12,  // Two's complement of B
                XOR  = 5'd13,
                NOR  = 5'd14,
                NOT  = 5'd15   // Bitwise invert of B
        } aluOpT;

endpackage

//--- hw/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Datapath word and storage sizes
`define WORD_WIDTH 32
`define REG_COUNT 16
`define MEM_DEPTH 512

// Instruction word layout
// Opcode sits in the top five bits
`define OPCODE_MSB 31

// Register fields are four bits wide, MSB given
`define RA_MSB 26
`define RB_MSB 22
`define RC_MSB 18

// Immediate field occupies the low bits, sign-extended on use
`define CONST_WIDTH 19

`endif
